//--- source/soc_pkg.sv
package soc_pkg;

    // Bus and data widths
    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  scan_t;
    typedef logic [3:0]  int_vec_t;

    // One data bus request from the core
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  we;
        logic  re;
    } bus_req_t;

    // Address map
    localparam addr_t ROM_BASE  = 64'h0000;
    localparam addr_t ROM_SIZE  = 64'h1000;
    localparam addr_t RAM_BASE  = 64'h1000;
    localparam addr_t RAM_SIZE  = 64'h2000;
    localparam int    MEM_WORDS = 3072;
    localparam int    MEM_AW    = $clog2(MEM_WORDS);
    localparam addr_t UART_ADDR = 64'h3000;
    localparam addr_t KEY_ADDR  = 64'h3008;

    // Keyboard and interrupt codes
    localparam int_vec_t KEY_VECTOR = 4'd1;
    localparam scan_t    BREAK_CODE = 8'hF0;
    localparam scan_t    EXT_CODE   = 8'hE0;

    // Clock cycles per serial bit, 2 or more
    localparam int BAUD_DIV = 16;
    localparam int BAUD_W   = $clog2(BAUD_DIV);

endpackage

//--- source/ps2_receiver.sv
module ps2_receiver (
    input  logic           CLOCK_50,
    input  logic           KEY0,
    input  logic           ps2_clk,
    input  logic           ps2_dat,
    output soc_pkg::scan_t scan,
    output logic           key_pressed
);
    import soc_pkg::*;

    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_prev;
    logic        clk_fall;
    logic [3:0]  bit_cnt;
    logic [9:0]  frame_q;
    logic [10:0] frame;
    logic        frame_end;
    logic        frame_ok;
    logic        accept_make;
    logic        break_seen;
    scan_t       code;

    // Both lines idle high, so the synchronizers start at one
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign clk_fall  = clk_prev & ~clk_sync[1];
    assign frame_end = clk_fall && (bit_cnt == 4'd10);

    // Start, 8 data LSB first, parity, stop
    assign frame    = {dat_sync[1], frame_q};
    assign code     = frame[8:1];
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    assign accept_make = frame_end && frame_ok && !break_seen &&
                         (code != BREAK_CODE) && (code != EXT_CODE);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_cnt <= '0;
        end else if (clk_fall) begin
            bit_cnt <= frame_end ? 4'd0 : bit_cnt + 4'd1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (clk_fall) begin
            frame_q <= {dat_sync[1], frame_q[9:1]};
        end
        if (accept_make) begin
            scan <= code;
        end
    end

    // Make/break tracking, E0 prefix is simply dropped
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            break_seen  <= 1'b0;
            key_pressed <= 1'b0;
        end else if (frame_end && frame_ok) begin
            if (code == BREAK_CODE) begin
                break_seen <= 1'b1;
            end else if (code != EXT_CODE) begin
                key_pressed <= !break_seen;
                break_seen  <= 1'b0;
            end
        end
    end

endmodule

//--- source/shared_memory.sv
module shared_memory (
    input  logic                       CLOCK_50,
    input  logic [soc_pkg::MEM_AW-1:0] fetch_index,
    input  logic [soc_pkg::MEM_AW-1:0] mem_index,
    input  logic                       mem_we,
    input  soc_pkg::word_t             mem_wdata,
    output soc_pkg::word_t             instr,
    output soc_pkg::word_t             mem_rdata
);
    import soc_pkg::*;

    // ROM and RAM share one array, ROM is only protected by the bus decoder
    word_t mem [MEM_WORDS];
    word_t fetch_word;

    // No init files, so start from all zeros
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Port A, instruction fetch only
    always_ff @(posedge CLOCK_50) begin
        fetch_word <= mem[fetch_index];
    end

    // Stored little endian, core wants byte 0 on top
    assign instr = {fetch_word[7:0], fetch_word[15:8],
                    fetch_word[23:16], fetch_word[31:24]};

    // Port B, read returns the word as it was before this write
    always_ff @(posedge CLOCK_50) begin
        if (mem_we) begin
            mem[mem_index] <= mem_wdata;
        end
        mem_rdata <= mem[mem_index];
    end

endmodule

//--- source/system_bus.sv
module system_bus (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  soc_pkg::bus_req_t          bus_req,
    input  soc_pkg::scan_t             key_code,
    input  soc_pkg::word_t             mem_rdata,
    output logic [soc_pkg::MEM_AW-1:0] mem_index,
    output logic                       mem_we,
    output soc_pkg::word_t             mem_wdata,
    output soc_pkg::data_t             bus_rdata,
    output logic                       tx_start,
    output soc_pkg::scan_t             tx_byte
);
    import soc_pkg::*;

    logic  rom_sel;
    logic  ram_sel;
    logic  uart_sel;
    logic  key_sel;
    logic  uart_wr;
    logic  uart_wr_q;
    logic  rd_mem_q;
    logic  rd_key_q;
    data_t rd_q;

    // ROM starts at zero, so only the upper bound matters
    assign rom_sel  = bus_req.addr < (ROM_BASE + ROM_SIZE);
    assign ram_sel  = (bus_req.addr >= RAM_BASE) &&
                      (bus_req.addr < (RAM_BASE + RAM_SIZE));
    assign uart_sel = bus_req.addr == UART_ADDR;
    assign key_sel  = bus_req.addr == KEY_ADDR;

    // Memory port, writes land in RAM only
    assign mem_index = bus_req.addr[MEM_AW+1:2];
    assign mem_we    = bus_req.we & ram_sel;
    assign mem_wdata = bus_req.wdata[31:0];

    // One start pulse per write burst to the serial port
    assign uart_wr  = bus_req.we & uart_sel;
    assign tx_start = uart_wr & ~uart_wr_q;
    assign tx_byte  = bus_req.wdata[7:0];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_wr_q <= 1'b0;
        end else begin
            uart_wr_q <= uart_wr;
        end
    end

    // Read pipe
    // Edge 0 samples the select with the memory read, edge 1 muxes,
    // edge 2 drives the answer on the bus
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_mem_q  <= 1'b0;
            rd_key_q  <= 1'b0;
            rd_q      <= '0;
            bus_rdata <= '0;
        end else begin
            rd_mem_q <= bus_req.re & (rom_sel | ram_sel);
            rd_key_q <= bus_req.re & key_sel;
            if (rd_mem_q) begin
                rd_q <= data_t'(mem_rdata);
            end else if (rd_key_q) begin
                rd_q <= data_t'(key_code);
            end else begin
                // Unmapped or idle reads as zero
                rd_q <= '0;
            end
            bus_rdata <= rd_q;
        end
    end

endmodule

//--- source/key_interrupt.sv
module key_interrupt (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  soc_pkg::scan_t    scan,
    input  logic              key_pressed,
    input  logic              int_ack,
    output soc_pkg::scan_t    key_code,
    output soc_pkg::int_vec_t int_vector,
    output logic              led_int,
    output logic              led_key
);
    import soc_pkg::*;

    logic pressed_q;
    logic press_edge;

    assign press_edge = key_pressed & ~pressed_q;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pressed_q  <= 1'b0;
            key_code   <= '0;
            int_vector <= '0;
        end else begin
            pressed_q <= key_pressed;
            if (press_edge) begin
                key_code <= scan;
            end
            // A new press takes priority over the ack
            if (press_edge && (scan != '0)) begin
                int_vector <= KEY_VECTOR;
            end else if (int_ack && (int_vector != '0)) begin
                int_vector <= '0;
            end
        end
    end

    assign led_int = |int_vector;
    assign led_key = key_pressed;

endmodule

//--- source/serial_tx.sv
module serial_tx (
    input  logic           CLOCK_50,
    input  logic           KEY0,
    input  logic           tx_start,
    input  soc_pkg::scan_t tx_byte,
    output logic           uart_txd
);
    import soc_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } tx_state_t;

    tx_state_t         state;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_idx;
    logic              baud_done;
    scan_t             shift_q;

    assign baud_done = baud_cnt == BAUD_W'(BAUD_DIV - 1);

    // Byte is loaded only when idle, so a late start cannot corrupt a frame
    always_ff @(posedge CLOCK_50) begin
        if (state == st_idle && tx_start) begin
            shift_q <= tx_byte;
        end else if (state == st_data && baud_done) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state    <= st_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            uart_txd <= 1'b1;
        end else begin
            baud_cnt <= baud_done ? '0 : baud_cnt + 1'b1;
            case (state)
                st_idle: begin
                    baud_cnt <= '0;
                    uart_txd <= 1'b1;
                    if (tx_start) begin
                        state    <= st_start;
                        uart_txd <= 1'b0;
                    end
                end
                st_start: if (baud_done) begin
                    state    <= st_data;
                    bit_idx  <= '0;
                    uart_txd <= shift_q[0];
                end
                st_data: if (baud_done) begin
                    if (bit_idx == 3'd7) begin
                        state    <= st_stop;
                        uart_txd <= 1'b1;
                    end else begin
                        bit_idx  <= bit_idx + 3'd1;
                        uart_txd <= shift_q[1];
                    end
                end
                // Stop bit, line already high
                st_stop: if (baud_done) begin
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- source/board_top.sv
module board_top (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              ps2_clk,
    input  logic              ps2_dat,
    input  soc_pkg::bus_req_t bus_req,
    input  soc_pkg::addr_t    fetch_addr,
    input  logic              int_ack,
    output soc_pkg::data_t    bus_rdata,
    output soc_pkg::word_t    instr,
    output soc_pkg::int_vec_t int_vector,
    output logic              led_int,
    output logic              led_key,
    output logic              uart_txd
);
    import soc_pkg::*;

    scan_t             scan;
    logic              key_pressed;
    scan_t             key_code;
    logic [MEM_AW-1:0] mem_index;
    logic              mem_we;
    word_t             mem_wdata;
    word_t             mem_rdata;
    logic              tx_start;
    scan_t             tx_byte;

    ps2_receiver u_ps2 (
        .CLOCK_50, .KEY0, .ps2_clk, .ps2_dat, .scan, .key_pressed
    );

    // Fetch uses the word index of the byte address
    shared_memory u_mem (
        .CLOCK_50,
        .fetch_index (fetch_addr[MEM_AW+1:2]),
        .mem_index, .mem_we, .mem_wdata, .instr, .mem_rdata
    );

    system_bus u_bus (
        .CLOCK_50, .KEY0, .bus_req, .key_code, .mem_rdata,
        .mem_index, .mem_we, .mem_wdata, .bus_rdata, .tx_start, .tx_byte
    );

    key_interrupt u_key (
        .CLOCK_50, .KEY0, .scan, .key_pressed, .int_ack,
        .key_code, .int_vector, .led_int, .led_key
    );

    serial_tx u_tx (
        .CLOCK_50, .KEY0, .tx_start, .tx_byte, .uart_txd
    );

endmodule

//--- verif/tb_clock.sv
module tb_clock (
    output logic CLOCK_50,
    output logic KEY0
);
    timeunit 1ns;
    timeprecision 1ns;

    // 100 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    // Reset low for 8 cycles, released on a falling edge
    initial begin
        KEY0 = 1'b0;
        repeat (8) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
    end

endmodule

//--- verif/tb_board.sv
module tb_board;
    timeunit 1ns;
    timeprecision 1ns;
    import soc_pkg::*;

    logic CLOCK_50, KEY0, ps2_clk, ps2_dat, int_ack, led_int, led_key, uart_txd;
    bus_req_t bus_req;
    addr_t fetch_addr;
    data_t bus_rdata;
    word_t instr;
    int_vec_t int_vector;

    int checks = 0;
    int errors = 0;
    logic [31:0] lfsr = 32'hc7314f3e;
    word_t ram_model [int];
    scan_t key_model = '0;
    scan_t got;
    // Expected bus_rdata of the last three requests with [2] due now
    data_t pipe [3] = '{default: '0};

    tb_clock u_clock (.CLOCK_50, .KEY0);

    board_top u_dut (
        .CLOCK_50, .KEY0, .ps2_clk, .ps2_dat, .bus_req, .fetch_addr, .int_ack,
        .bus_rdata, .instr, .int_vector, .led_int, .led_key, .uart_txd
    );

    // Ack clears a pending vector on the next edge unless a new press arrives
    ack_clears_vector: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (int_ack && (int_vector != '0) && !$rose(led_key)) |=> (int_vector == '0))
    else begin
        errors++;
        $display("ERROR at %0t: int_vector is %h, expected 0 after int_ack", $time, int_vector);
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output data_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic compare(input string name, input data_t value, input data_t expected);
        checks++;
        assert (value == expected) else begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, value, expected);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    function automatic logic in_ram(input addr_t a);
        return (a >= RAM_BASE) && (a < RAM_BASE + RAM_SIZE);
    endfunction

    // ROM holds zeros since there are no init files
    function automatic data_t expect_read(input addr_t a);
        if (in_ram(a) && ram_model.exists(int'(a >> 2))) begin
            return data_t'(ram_model[int'(a >> 2)]);
        end else if (a == KEY_ADDR) begin
            return data_t'(key_model);
        end
        return '0;
    endfunction

    task automatic bus_step(input addr_t a, input data_t d, input logic we, input logic re);
        data_t expected;
        expected = re ? expect_read(a) : '0;
        @(negedge CLOCK_50);
        compare("bus_rdata", bus_rdata, pipe[2]);
        pipe[2] = pipe[1];
        pipe[1] = pipe[0];
        pipe[0] = expected;
        if (we && in_ram(a)) begin
            ram_model[int'(a >> 2)] = d[31:0];
        end
        bus_req = '{addr: a, wdata: d, we: we, re: re};
    endtask

    task automatic flush_bus();
        repeat (3) bus_step('0, '0, 1'b0, 1'b0);
    endtask

    // Returns right after the eleventh falling PS/2 clock edge
    task automatic ps2_send(input scan_t code, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(negedge CLOCK_50);
            ps2_dat = frame[i];
            repeat (4) @(negedge CLOCK_50);
            ps2_clk = 1'b0;
            if (i < 10) begin
                repeat (10) @(negedge CLOCK_50);
                ps2_clk = 1'b1;
                repeat (5) @(negedge CLOCK_50);
            end
        end
    endtask

    task automatic ps2_release();
        repeat (10) @(negedge CLOCK_50);
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        repeat (20) @(negedge CLOCK_50);
    endtask

    task automatic wait_key_state(input logic level, input int_vec_t vec, input int limit);
        int n;
        n = 0;
        while ((led_key !== level || int_vector !== vec) && n < limit) begin
            @(negedge CLOCK_50);
            n++;
        end
        compare("led_key", data_t'(led_key), data_t'(level));
        compare("int_vector", data_t'(int_vector), data_t'(vec));
        compare("led_int", data_t'(led_int), data_t'(vec != '0));
    endtask

    // Samples each bit at its centre counted from the start bit edge
    task automatic serial_receive(output scan_t value);
        int n;
        value = '0;
        n = 0;
        while (uart_txd !== 1'b0 && n < 40) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (uart_txd !== 1'b0) begin
            note_failure("no serial start bit after the UART write");
        end else begin
            repeat (BAUD_DIV / 2) @(negedge CLOCK_50);
            compare("uart_txd start bit", data_t'(uart_txd), '0);
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD_DIV) @(negedge CLOCK_50);
                value[i] = uart_txd;
            end
            repeat (BAUD_DIV) @(negedge CLOCK_50);
            compare("uart_txd stop bit", data_t'(uart_txd), 64'd1);
        end
    endtask

    initial begin
        data_t r;
        addr_t a;
        addr_t addrs[$];
        scan_t code;
        scan_t tx_a;
        int n;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        int_ack = 1'b0;
        bus_req = '0;
        fetch_addr = '0;
        n = 0;
        while (KEY0 !== 1'b1 && n < 20) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (KEY0 !== 1'b1) begin
            note_failure("reset was never released");
        end
        compare("int_vector", data_t'(int_vector), '0);
        compare("led_int", data_t'(led_int), '0);
        compare("led_key", data_t'(led_key), '0);
        compare("uart_txd", data_t'(uart_txd), 64'd1);
        compare("bus_rdata", bus_rdata, '0);

        // RAM writes, then back-to-back and spaced reads
        for (int i = 0; i < 8; i++) begin
            take_bits(11, r);
            a = RAM_BASE + {51'd0, r[10:0], 2'b00};
            take_bits(64, r);
            bus_step(a, r, 1'b1, 1'b0);
            addrs.push_back(a);
        end
        foreach (addrs[i]) bus_step(addrs[i], '0, 1'b0, 1'b1);
        foreach (addrs[i]) begin
            bus_step(addrs[i], '0, 1'b0, 1'b1);
            bus_step('0, '0, 1'b0, 1'b0);
        end

        // ROM write ignored, unmapped alias of a written word, read during write
        bus_step(64'h0100, 64'h1234_5678_9abc_def0, 1'b1, 1'b0);
        bus_step(64'h0100, '0, 1'b0, 1'b1);
        bus_step(addrs[0] + 64'h4000, '0, 1'b0, 1'b1);
        take_bits(64, r);
        bus_step(addrs[0], r, 1'b1, 1'b1);
        bus_step(addrs[0], '0, 1'b0, 1'b1);
        flush_bus();

        // Fetch port sees the written word byte reversed
        take_bits(11, r);
        a = RAM_BASE + {51'd0, r[10:0], 2'b00};
        take_bits(32, r);
        bus_step(a, r, 1'b1, 1'b0);
        flush_bus();
        @(negedge CLOCK_50);
        fetch_addr = a;
        @(negedge CLOCK_50);
        compare("instr", data_t'(instr), data_t'({r[7:0], r[15:8], r[23:16], r[31:24]}));

        // Key press, interrupt and ack
        take_bits(7, r);
        code = {1'b0, r[6:0]} | 8'h01;
        key_model = code;
        ps2_send(code, 1'b0);
        wait_key_state(1'b1, KEY_VECTOR, 5);
        ps2_release();
        bus_step(KEY_ADDR, '0, 1'b0, 1'b1);
        flush_bus();
        @(negedge CLOCK_50);
        int_ack = 1'b1;
        @(negedge CLOCK_50);
        int_ack = 1'b0;
        compare("int_vector", data_t'(int_vector), '0);
        compare("led_int", data_t'(led_int), '0);

        // Break sequence, then a frame with bad parity
        ps2_send(BREAK_CODE, 1'b0);
        ps2_release();
        ps2_send(code, 1'b0);
        wait_key_state(1'b0, '0, 5);
        ps2_release();
        compare("int_vector", data_t'(int_vector), '0);
        take_bits(7, r);
        ps2_send({1'b0, r[6:0]} | 8'h01, 1'b1);
        ps2_release();
        compare("led_key", data_t'(led_key), '0);
        compare("int_vector", data_t'(int_vector), '0);
        bus_step(KEY_ADDR, '0, 1'b0, 1'b1);
        flush_bus();

        // One frame from a held strobe and a dropped write mid frame
        take_bits(8, r);
        tx_a = r[7:0];
        take_bits(8, r);
        fork
            begin
                repeat (3) bus_step(UART_ADDR, data_t'(tx_a), 1'b1, 1'b0);
                repeat (40) bus_step('0, '0, 1'b0, 1'b0);
                bus_step(UART_ADDR, r, 1'b1, 1'b0);
                flush_bus();
            end
            serial_receive(got);
        join
        compare("uart byte", data_t'(got), data_t'(tx_a));
        repeat (30 * BAUD_DIV) begin
            @(negedge CLOCK_50);
            compare("uart_txd", data_t'(uart_txd), 64'd1);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
source/soc_pkg.sv
source/ps2_receiver.sv
source/shared_memory.sv
source/system_bus.sv
source/key_interrupt.sv
source/serial_tx.sv
source/board_top.sv
verif/tb_clock.sv
verif/tb_board.sv

//--- Makefile
TOP = tb_board

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir
